/* src/dma_settings.svh */
// DMA controller settings for channel count, block length and register offsets
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

`define DMA_CHANNELS     4
`define DMA_BLOCK_WORDS  4

// CPU register offsets
`define DMA_ADDR_CMD     4'd8
`define DMA_ADDR_REQ     4'd9
`define DMA_ADDR_SMASK   4'd10
`define DMA_ADDR_MODE    4'd11
`define DMA_ADDR_MCLR    4'd13
`define DMA_ADDR_CLRMASK 4'd14
`define DMA_ADDR_WMASK   4'd15

`endif

/* src/dma_bus_pkg.sv */
// DMA CPU bus types for register offsets, the write byte and decoded strobes
`include "dma_settings.svh"

package dma_bus_pkg;

    typedef enum logic [3:0] {
        DMA_REG_CMD     = `DMA_ADDR_CMD,
        DMA_REG_REQ     = `DMA_ADDR_REQ,
        DMA_REG_SMASK   = `DMA_ADDR_SMASK,
        DMA_REG_MODE    = `DMA_ADDR_MODE,
        DMA_REG_MCLR    = `DMA_ADDR_MCLR,
        DMA_REG_CLRMASK = `DMA_ADDR_CLRMASK,
        DMA_REG_WMASK   = `DMA_ADDR_WMASK
    } dma_reg_addr_e;

    // Command register layout
    typedef struct packed {
        logic       reserved_7;
        logic       dreq_low;
        logic       reserved_5;
        logic       rotate;
        logic       reserved_3;
        logic       ctrl_disable;
        logic [1:0] reserved_1_0;
    } dma_cmd_word_t;

    // Mask, request and mode layout
    typedef struct packed {
        logic [4:0] mode;
        logic       set_bit;
        logic [1:0] chan_sel;
    } dma_chan_word_t;

    typedef union packed {
        dma_cmd_word_t  cmd;
        dma_chan_word_t chan;
    } dma_write_word_u;

    typedef struct packed {
        logic            write_command;
        logic            write_request;
        logic            set_reset_mask;
        logic            write_all_mask;
        logic            master_clear;
        logic            clear_mask;
        logic            write_mode;
        dma_write_word_u data;
    } dma_strobe_t;

endpackage

/* src/dma_chan_pkg.sv */
// DMA per-channel types with rotate and lowest-bit priority helpers
`include "dma_settings.svh"

package dma_chan_pkg;

    typedef logic [`DMA_CHANNELS-1:0]         dma_chan_vec_t;
    typedef logic [$clog2(`DMA_CHANNELS)-1:0] dma_chan_id_t;

    typedef struct packed {
        logic         active;
        dma_chan_id_t channel;
        logic [2:0]   words_left;
    } dma_grant_t;

    function automatic dma_chan_vec_t rotate_right(dma_chan_vec_t vec, dma_chan_id_t amount);
        dma_chan_vec_t result;
        for (int i = 0; i < `DMA_CHANNELS; i++) begin
            result[i] = vec[(i + int'(amount)) % `DMA_CHANNELS];
        end
        return result;
    endfunction

    function automatic dma_chan_vec_t rotate_left(dma_chan_vec_t vec, dma_chan_id_t amount);
        dma_chan_vec_t result;
        for (int i = 0; i < `DMA_CHANNELS; i++) begin
            result[(i + int'(amount)) % `DMA_CHANNELS] = vec[i];
        end
        return result;
    endfunction

    // Keeps only the lowest set bit
    function automatic dma_chan_vec_t resolve_priority(dma_chan_vec_t vec);
        return vec & (~vec + dma_chan_vec_t'(1));
    endfunction

endpackage

/* src/dma_reg_decode.sv */
// DMA register write decoder producing strobes and holding per-channel mode
module dma_reg_decode
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            cs_i,
    input  logic            wr_i,
    input  dma_reg_addr_e   addr_i,
    input  dma_write_word_u data_i,
    output dma_strobe_t     strobes_o,
    output dma_chan_vec_t   edge_mode_o
);

    logic write_en;

    assign write_en = cs_i && wr_i;

    always_comb begin
        strobes_o      = '0;
        strobes_o.data = data_i;
        if (write_en) begin
            case (addr_i)
                DMA_REG_CMD:     strobes_o.write_command  = 1'b1;
                DMA_REG_REQ:     strobes_o.write_request  = 1'b1;
                DMA_REG_SMASK:   strobes_o.set_reset_mask = 1'b1;
                DMA_REG_MODE:    strobes_o.write_mode     = 1'b1;
                DMA_REG_MCLR:    strobes_o.master_clear   = 1'b1;
                DMA_REG_CLRMASK: strobes_o.clear_mask     = 1'b1;
                DMA_REG_WMASK:   strobes_o.write_all_mask = 1'b1;
                default: ;
            endcase
        end
    end

    // Mode bits 7:6 of zero select demand mode
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            edge_mode_o <= '0;
        end else if (strobes_o.master_clear) begin
            edge_mode_o <= '0;
        end else if (strobes_o.write_mode) begin
            edge_mode_o[data_i.chan.chan_sel] <= (data_i.chan.mode[4:3] != 2'b00);
        end
    end

endmodule

/* src/dma_priority_encoder.sv */
// DMA request priority encoder with command, mask and request registers
`include "dma_settings.svh"

module dma_priority_encoder
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  dma_strobe_t   strobes_i,
    input  dma_chan_vec_t edge_mode_i,
    input  dma_chan_id_t  dma_rotate_i,
    input  dma_chan_vec_t dreq_i,
    input  dma_chan_vec_t ack_vec_i,
    input  logic          eop_int_i,
    output dma_chan_vec_t request_state_o,
    output dma_chan_vec_t encoded_dma_o
);

    logic          ctrl_disable;
    logic          rotate_en;
    logic          dreq_low;
    dma_chan_vec_t mask_reg;
    dma_chan_vec_t request_reg;
    dma_chan_vec_t dreq_ff;
    dma_chan_vec_t dreq_lock;
    dma_chan_vec_t rotated;
    dma_chan_vec_t picked;

    // Command register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ctrl_disable <= 1'b0;
            rotate_en    <= 1'b0;
            dreq_low     <= 1'b0;
        end else if (strobes_i.master_clear) begin
            ctrl_disable <= 1'b0;
            rotate_en    <= 1'b0;
            dreq_low     <= 1'b0;
        end else if (strobes_i.write_command) begin
            ctrl_disable <= strobes_i.data.cmd.ctrl_disable;
            rotate_en    <= strobes_i.data.cmd.rotate;
            dreq_low     <= strobes_i.data.cmd.dreq_low;
        end
    end

    // DREQ sampled with the programmed sense
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dreq_ff <= '0;
        end else if (strobes_i.master_clear) begin
            dreq_ff <= '0;
        end else begin
            dreq_ff <= dreq_low ? ~dreq_i : dreq_i;
        end
    end

    for (genvar ch = 0; ch < `DMA_CHANNELS; ch++) begin : g_chan
        logic chan_hit;

        assign chan_hit = (strobes_i.data.chan.chan_sel == dma_chan_id_t'(ch));

        // Mask bit, set on reset and master clear
        always_ff @(posedge clock or posedge reset) begin
            if (reset) begin
                mask_reg[ch] <= 1'b1;
            end else if (strobes_i.master_clear) begin
                mask_reg[ch] <= 1'b1;
            end else if (strobes_i.clear_mask) begin
                mask_reg[ch] <= 1'b0;
            end else if (strobes_i.set_reset_mask && chan_hit) begin
                mask_reg[ch] <= strobes_i.data.chan.set_bit;
            end else if (strobes_i.write_all_mask) begin
                mask_reg[ch] <= strobes_i.data[ch];
            end
        end

        // Software request, dropped when its block ends
        always_ff @(posedge clock or posedge reset) begin
            if (reset) begin
                request_reg[ch] <= 1'b0;
            end else if (strobes_i.master_clear || strobes_i.clear_mask) begin
                request_reg[ch] <= 1'b0;
            end else if (strobes_i.write_request && chan_hit) begin
                request_reg[ch] <= strobes_i.data.chan.set_bit;
            end else if (eop_int_i && ack_vec_i[ch]) begin
                request_reg[ch] <= 1'b0;
            end
        end

        // Edge lock holds a served request until DREQ drops
        always_ff @(posedge clock or posedge reset) begin
            if (reset) begin
                dreq_lock[ch] <= 1'b0;
            end else if (strobes_i.master_clear || strobes_i.clear_mask) begin
                dreq_lock[ch] <= 1'b0;
            end else if (!edge_mode_i[ch]) begin
                dreq_lock[ch] <= 1'b0;
            end else if (eop_int_i && ack_vec_i[ch]) begin
                dreq_lock[ch] <= 1'b1;
            end else if (!dreq_ff[ch] && !ack_vec_i[ch]) begin
                dreq_lock[ch] <= 1'b0;
            end
        end
    end

    assign request_state_o = (dreq_ff & ~dreq_lock & ~mask_reg) | request_reg;

    always_comb begin
        rotated = rotate_en ? rotate_right(request_state_o, dma_rotate_i) : request_state_o;
        picked  = resolve_priority(rotated);
        if (ctrl_disable) begin
            encoded_dma_o = '0;
        end else if (rotate_en) begin
            encoded_dma_o = rotate_left(picked, dma_rotate_i);
        end else begin
            encoded_dma_o = picked;
        end
    end

    a_pick_onehot: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(encoded_dma_o)
    );

endmodule

/* src/dma_grant_sequencer.sv */
// DMA grant sequencer driving HRQ, DACK and EOP for one block per grant
`include "dma_settings.svh"

module dma_grant_sequencer
    import dma_chan_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  dma_chan_vec_t encoded_dma_i,
    input  logic          hlda_i,
    input  logic          eop_i,
    output logic          hrq_o,
    output dma_chan_vec_t dack_o,
    output logic          eop_o,
    output dma_chan_id_t  dma_rotate_o
);

    localparam logic [2:0] BLOCK_WORDS = 3'(`DMA_BLOCK_WORDS);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_REQUEST,
        SEQ_TRANSFER
    } seq_state_e;

    seq_state_e   state;
    dma_grant_t   grant;
    dma_chan_id_t pick_id;
    logic         last_cycle;

    // One-hot pick to channel index
    always_comb begin
        pick_id = '0;
        for (int i = 0; i < `DMA_CHANNELS; i++) begin
            if (encoded_dma_i[i]) begin
                pick_id = dma_chan_id_t'(i);
            end
        end
    end

    // Block ends on the last word or on external EOP
    assign last_cycle = (state == SEQ_TRANSFER) && ((grant.words_left == 3'd1) || eop_i);

    assign hrq_o  = grant.active;
    assign eop_o  = last_cycle;
    assign dack_o = (state == SEQ_TRANSFER) ? (dma_chan_vec_t'(1) << grant.channel) : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= SEQ_IDLE;
            grant        <= '0;
            dma_rotate_o <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (|encoded_dma_i) begin
                        grant.active     <= 1'b1;
                        grant.channel    <= pick_id;
                        grant.words_left <= BLOCK_WORDS;
                        state            <= SEQ_REQUEST;
                    end
                end
                SEQ_REQUEST: begin
                    if (hlda_i) begin
                        state <= SEQ_TRANSFER;
                    end
                end
                SEQ_TRANSFER: begin
                    if (last_cycle) begin
                        grant.active <= 1'b0;
                        dma_rotate_o <= grant.channel + 2'd1;
                        state        <= SEQ_IDLE;
                    end else begin
                        grant.words_left <= grant.words_left - 3'd1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    a_dack_needs_hrq: assert property (
        @(posedge clock) disable iff (reset)
        (|dack_o) |-> hrq_o
    );

endmodule

/* src/dma_arbiter_top.sv */
// DMA request and grant path joining decoder, priority encoder and sequencer
module dma_arbiter_top
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       cs_i,
    input  logic       wr_i,
    input  logic [3:0] addr_i,
    input  logic [7:0] data_i,
    input  logic [3:0] dreq_i,
    input  logic       hlda_i,
    input  logic       eop_i,
    output logic       hrq_o,
    output logic [3:0] dack_o,
    output logic       eop_o
);

    dma_strobe_t   strobes;
    dma_chan_vec_t edge_mode;
    dma_chan_vec_t encoded_dma;
    dma_chan_id_t  dma_rotate;

    dma_reg_decode u_decode (
        .clock       (clock),
        .reset       (reset),
        .cs_i        (cs_i),
        .wr_i        (wr_i),
        .addr_i      (dma_reg_addr_e'(addr_i)),
        .data_i      (dma_write_word_u'(data_i)),
        .strobes_o   (strobes),
        .edge_mode_o (edge_mode)
    );

    // DACK and EOP return to the encoder
    dma_priority_encoder u_encoder (
        .clock           (clock),
        .reset           (reset),
        .strobes_i       (strobes),
        .edge_mode_i     (edge_mode),
        .dma_rotate_i    (dma_rotate),
        .dreq_i          (dreq_i),
        .ack_vec_i       (dack_o),
        .eop_int_i       (eop_o),
        .request_state_o (),
        .encoded_dma_o   (encoded_dma)
    );

    dma_grant_sequencer u_sequencer (
        .clock         (clock),
        .reset         (reset),
        .encoded_dma_i (encoded_dma),
        .hlda_i        (hlda_i),
        .eop_i         (eop_i),
        .hrq_o         (hrq_o),
        .dack_o        (dack_o),
        .eop_o         (eop_o),
        .dma_rotate_o  (dma_rotate)
    );

endmodule

/* dv/dma_arbiter_tb.sv */
// Testbench for the DMA request and grant path with a cycle-level reference model
`include "dma_settings.svh"

module dma_arbiter_tb;

    localparam int NUM_SCENARIOS = 48;
    localparam int WATCHDOG_TIME = NUM_SCENARIOS * (`DMA_BLOCK_WORDS + 12) * 100 * 2;

    logic       clock;
    logic       reset;
    logic       cs_i;
    logic       wr_i;
    logic [3:0] addr_i;
    logic [7:0] data_i;
    logic [3:0] dreq_i;
    logic       hlda_i;
    logic       eop_i;
    logic       hrq_o;
    logic [3:0] dack_o;
    logic       eop_o;
    logic [1:0] hlda_wait;

    // Reference model state
    logic [7:0] m_cmd;
    logic [3:0] m_mask;
    logic [3:0] m_req;
    logic [3:0] m_edge;
    logic [3:0] m_dreq_q;
    logic [3:0] m_lock;
    logic [1:0] m_state;
    logic [1:0] m_chan;
    logic [2:0] m_words;
    logic [1:0] m_rot;
    logic [2:0] m_pick;
    logic [3:0] exp_dack;
    logic       exp_eop;
    logic       exp_hrq;

    dma_arbiter_top uut (
        .clock  (clock),
        .reset  (reset),
        .cs_i   (cs_i),
        .wr_i   (wr_i),
        .addr_i (addr_i),
        .data_i (data_i),
        .dreq_i (dreq_i),
        .hlda_i (hlda_i),
        .eop_i  (eop_i),
        .hrq_o  (hrq_o),
        .dack_o (dack_o),
        .eop_o  (eop_o)
    );

    // Valid flag and index of the winning channel, searched from the start offset
    function automatic logic [2:0] pick_channel(logic [3:0] pend, logic rot_en, logic [1:0] start);
        logic [1:0] idx;
        logic [2:0] result;
        result = 3'b0;
        for (int n = `DMA_CHANNELS - 1; n >= 0; n--) begin
            idx = rot_en ? start + 2'(n) : 2'(n);
            if (pend[idx]) begin
                result = {1'b1, idx};
            end
        end
        return result;
    endfunction

    assign m_pick   = m_cmd[2] ? 3'b0
                    : pick_channel((m_dreq_q & ~m_lock & ~m_mask) | m_req, m_cmd[4], m_rot);
    assign exp_hrq  = (m_state != 2'd0);
    assign exp_dack = (m_state == 2'd2) ? (4'b1 << m_chan) : 4'b0;
    assign exp_eop  = (m_state == 2'd2) && ((m_words == 3'd1) || eop_i);

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            m_cmd    <= '0;
            m_mask   <= '1;
            m_req    <= '0;
            m_edge   <= '0;
            m_dreq_q <= '0;
            m_lock   <= '0;
            m_state  <= 2'd0;
            m_chan   <= '0;
            m_words  <= '0;
            m_rot    <= '0;
        end else begin
            m_dreq_q <= m_cmd[6] ? ~dreq_i : dreq_i;
            case (m_state)
                2'd0: begin
                    if (m_pick[2]) begin
                        m_chan  <= m_pick[1:0];
                        m_words <= 3'(`DMA_BLOCK_WORDS);
                        m_state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (hlda_i) begin
                        m_state <= 2'd2;
                    end
                end
                default: begin
                    if (exp_eop) begin
                        m_state <= 2'd0;
                        m_rot   <= m_chan + 2'd1;
                        m_req[m_chan] <= 1'b0;
                    end else begin
                        m_words <= m_words - 3'd1;
                    end
                end
            endcase
            for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
                if (!m_edge[ch]) begin
                    m_lock[ch] <= 1'b0;
                end else if (exp_eop && exp_dack[ch]) begin
                    m_lock[ch] <= 1'b1;
                end else if (!m_dreq_q[ch] && !exp_dack[ch]) begin
                    m_lock[ch] <= 1'b0;
                end
            end
            // A register write wins over the end-of-block updates
            if (cs_i && wr_i) begin
                case (addr_i)
                    `DMA_ADDR_CMD:     m_cmd <= data_i;
                    `DMA_ADDR_REQ:     m_req[data_i[1:0]] <= data_i[2];
                    `DMA_ADDR_SMASK:   m_mask[data_i[1:0]] <= data_i[2];
                    `DMA_ADDR_MODE:    m_edge[data_i[1:0]] <= (data_i[7:6] != 2'b00);
                    `DMA_ADDR_WMASK:   m_mask <= data_i[3:0];
                    `DMA_ADDR_MCLR: begin
                        m_cmd    <= '0;
                        m_mask   <= '1;
                        m_req    <= '0;
                        m_edge   <= '0;
                        m_dreq_q <= '0;
                        m_lock   <= '0;
                    end
                    `DMA_ADDR_CLRMASK: begin
                        m_mask <= '0;
                        m_req  <= '0;
                        m_lock <= '0;
                    end
                    default: ;
                endcase
            end
        end
    end

    task automatic flag_mismatch(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        $display("Fail %s expected %h got %h", name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    a_hrq: assert property (@(posedge clock) disable iff (reset) hrq_o == exp_hrq)
        else flag_mismatch("hrq_o", 8'($sampled(exp_hrq)), 8'($sampled(hrq_o)));
    a_dack: assert property (@(posedge clock) disable iff (reset) dack_o == exp_dack)
        else flag_mismatch("dack_o", 8'($sampled(exp_dack)), 8'($sampled(dack_o)));
    a_eop: assert property (@(posedge clock) disable iff (reset) eop_o == exp_eop)
        else flag_mismatch("eop_o", 8'($sampled(exp_eop)), 8'($sampled(eop_o)));

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests reached their end");
        $display("sim failed");
        $fatal(1);
    end

    // HLDA answers HRQ after 0 to 3 cycles
    initial begin
        hlda_i    = 1'b0;
        hlda_wait = 2'd0;
        forever begin
            @(negedge clock);
            if (!hrq_o) begin
                hlda_i    = 1'b0;
                hlda_wait = 2'($urandom_range(3, 0));
            end else if (!hlda_i) begin
                if (hlda_wait == 2'd0) begin
                    hlda_i = 1'b1;
                end else begin
                    hlda_wait = hlda_wait - 2'd1;
                end
            end
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(negedge clock);
        cs_i   = 1'b1;
        wr_i   = 1'b1;
        addr_i = addr;
        data_i = data;
        @(negedge clock);
        cs_i = 1'b0;
        wr_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    // Returns at the falling edge inside the last transfer cycle
    task automatic wait_block_end();
        do @(negedge clock); while (!eop_o);
    endtask

    initial begin
        void'($urandom(32'h3e9ea094));
        reset  = 1'b1;
        cs_i   = 1'b0;
        wr_i   = 1'b0;
        addr_i = 4'd0;
        data_i = 8'd0;
        dreq_i = 4'd0;
        eop_i  = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // All channels masked after reset
        dreq_i = 4'hf;
        idle_cycles(8);
        dreq_i = 4'h0;

        // Fixed priority over random patterns
        write_reg(`DMA_ADDR_WMASK, 8'h00);
        write_reg(`DMA_ADDR_CMD, 8'h00);
        repeat (10) begin
            dreq_i = 4'($urandom_range(15, 1));
            wait_block_end();
            dreq_i = 4'h0;
            idle_cycles(2);
        end

        // Rotating priority
        write_reg(`DMA_ADDR_CMD, 8'h10);
        dreq_i = 4'hf;
        repeat (8) wait_block_end();
        dreq_i = 4'h0;
        idle_cycles(3);

        // Software requests with the master-cleared mask
        write_reg(`DMA_ADDR_MCLR, 8'h00);
        dreq_i = 4'hf;
        idle_cycles(8);
        dreq_i = 4'h0;
        write_reg(`DMA_ADDR_REQ, 8'h06);
        wait_block_end();
        idle_cycles(8);
        write_reg(`DMA_ADDR_REQ, 8'h05);
        do @(negedge clock); while (dack_o == 4'h0);
        @(negedge clock);
        eop_i = 1'b1;
        @(negedge clock);
        eop_i = 1'b0;
        idle_cycles(4);

        // Low DREQ sense, then disable
        dreq_i = 4'hf;
        write_reg(`DMA_ADDR_CMD, 8'h40);
        idle_cycles(2);
        write_reg(`DMA_ADDR_WMASK, 8'h00);
        idle_cycles(8);
        dreq_i = 4'hd;
        wait_block_end();
        dreq_i = 4'hf;
        write_reg(`DMA_ADDR_CMD, 8'h44);
        dreq_i = 4'h0;
        idle_cycles(8);
        write_reg(`DMA_ADDR_CMD, 8'h40);
        wait_block_end();
        dreq_i = 4'hf;
        idle_cycles(3);

        // Single-channel mask
        write_reg(`DMA_ADDR_WMASK, 8'h0f);
        write_reg(`DMA_ADDR_CMD, 8'h00);
        dreq_i = 4'h0;
        write_reg(`DMA_ADDR_WMASK, 8'h00);
        write_reg(`DMA_ADDR_SMASK, 8'h04);
        dreq_i = 4'h1;
        idle_cycles(8);
        dreq_i = 4'h3;
        wait_block_end();
        dreq_i = 4'h0;
        idle_cycles(3);

        // Edge mode on channel 0
        write_reg(`DMA_ADDR_MCLR, 8'h00);
        write_reg(`DMA_ADDR_WMASK, 8'h00);
        write_reg(`DMA_ADDR_MODE, 8'h40);
        dreq_i = 4'h1;
        wait_block_end();
        idle_cycles(8);
        dreq_i = 4'h0;
        idle_cycles(3);
        dreq_i = 4'h1;
        wait_block_end();
        dreq_i = 4'h0;
        idle_cycles(10);

        $display("sim passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/dma_bus_pkg.sv
src/dma_chan_pkg.sv
src/dma_reg_decode.sv
src/dma_priority_encoder.sv
src/dma_grant_sequencer.sv
src/dma_arbiter_top.sv
dv/dma_arbiter_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module dma_arbiter_tb -o dma_sim &&
./obj_dir/dma_sim || exit 1
